// ==== bus_pkg.sv ====
// APB bus definitions for the interrupt subsystem.
// Holds the bus widths, the register offsets seen by software and
// the register operation passed from the APB port to the blocks.

package bus_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// every register is one full data word wide.
	localparam int DATA_W = 32;
	// the subsystem decodes a small byte-addressed window.
	localparam int ADDR_W = 8;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// interrupt controller registers; bit 2 picks one of the two.
	localparam logic [ADDR_W-1:0] REG_MASK   = 8'h00;
	localparam logic [ADDR_W-1:0] REG_STATUS = 8'h04;
	// interval timer registers; the count is read only.
	localparam logic [ADDR_W-1:0] REG_PERIOD = 8'h08;
	localparam logic [ADDR_W-1:0] REG_COUNT  = 8'h0C;
	// source number of the last interrupt taken, read only.
	localparam logic [ADDR_W-1:0] REG_CAUSE  = 8'h10;

	// the operation a block sees; op_none outside of a legal access.
	typedef enum logic [1:0] {
		op_none  = 2'd0,
		op_read  = 2'd1,
		op_write = 2'd2
	} bus_op_e;

endpackage

// ==== irq_pkg.sv ====
// Interrupt definitions shared by the controller and the output stage.
// Covers the numbering of the sources, the width of a source number
// and the encoding of the controller state.

package irq_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// source numbering
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// status and mask bits 0 to 7 are implemented.
	// bit 0 is the global enable in the mask and reads 1 in the status.
	localparam int NUM_SRC = 8;

	// the interval timer raises status bit 1.
	localparam int SRC_TIMER = 1;

	// external lines fill status bits 2 up to NUM_SRC-1.
	localparam int EXT_SRC = 6;

	// a source number fits in three bits.
	localparam int CAUSE_W = 3;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// controller state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// st_wait_ack covers the whole time the processor has not acked.
	typedef enum logic {
		st_idle     = 1'b0,
		st_wait_ack = 1'b1
	} irq_state_e;

endpackage

// ==== apb_reg_port.sv ====
// APB slave port of the interrupt subsystem.
// Qualifies the access phase, decodes the register offset into a
// block select or an error, and muxes read data back onto prdata.
// Zero wait states; illegal accesses never reach the blocks.

`timescale 1ns/100ps

module apb_reg_port (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [bus_pkg::ADDR_W-1:0]   paddr,
	input  logic [bus_pkg::DATA_W-1:0]   pwdata,
	output logic [bus_pkg::DATA_W-1:0]   prdata,
	output logic                         pready,
	output logic                         pslverr,
	output bus_pkg::bus_op_e             reg_op,
	output logic [bus_pkg::ADDR_W-1:0]   reg_addr,
	output logic [bus_pkg::DATA_W-1:0]   reg_wdata,
	output logic                         ctrl_sel,
	output logic                         timer_sel,
	input  logic [bus_pkg::DATA_W-1:0]   ctrl_rdata,
	input  logic [bus_pkg::DATA_W-1:0]   timer_rdata,
	input  logic [irq_pkg::CAUSE_W-1:0]  cause
);
	import bus_pkg::*;
	import irq_pkg::*;

	logic setup_q;
	logic access;
	logic hit_ctrl, hit_period, hit_count, hit_cause;
	logic bad;

	// remember a setup phase so that only the access phase right after
	// it turns into a register operation.
	always_ff @(posedge clk) begin
		if (rst) begin
			setup_q <= 1'b0;
		end else begin
			setup_q <= psel && !penable;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// offset decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign hit_ctrl   = (paddr == REG_MASK) || (paddr == REG_STATUS);
	assign hit_period = (paddr == REG_PERIOD);
	assign hit_count  = (paddr == REG_COUNT);
	assign hit_cause  = (paddr == REG_CAUSE);

	// unmapped offsets and writes to read-only registers are errors.
	assign bad = !(hit_ctrl || hit_period || hit_count || hit_cause)
		|| (pwrite && (hit_count || hit_cause));

	// the count register is readable, so the timer is selected for it
	// only on reads.
	assign ctrl_sel  = hit_ctrl;
	assign timer_sel = hit_period || (hit_count && !pwrite);

	// every access phase completes at once.
	assign pready  = psel && penable;
	assign pslverr = psel && penable && bad;

	// the blocks only ever see legal accesses.
	assign access    = psel && penable && setup_q && !bad;
	assign reg_op    = !access ? op_none : (pwrite ? op_write : op_read);
	assign reg_addr  = paddr;
	assign reg_wdata = pwdata;

	// read mux; an erroring address returns zero.
	always_comb begin
		prdata = '0;
		if (!bad) begin
			if (ctrl_sel) begin
				prdata = ctrl_rdata;
			end else if (timer_sel) begin
				prdata = timer_rdata;
			end else if (hit_cause) begin
				prdata = {{(DATA_W-CAUSE_W){1'b0}}, cause};
			end
		end
	end

endmodule

// ==== irq_timer.sv ====
// Programmable interval timer, one of the interrupt sources.
// A down counter reloads from the period register when it reaches
// zero and pulses timer_event for that cycle. A period of zero
// stops the timer.

`timescale 1ns/100ps

module irq_timer (
	input  logic                        clk,
	input  logic                        rst,
	input  bus_pkg::bus_op_e            reg_op,
	input  logic [bus_pkg::ADDR_W-1:0]  reg_addr,
	input  logic [bus_pkg::DATA_W-1:0]  reg_wdata,
	input  logic                        timer_sel,
	output logic [bus_pkg::DATA_W-1:0]  timer_rdata,
	output logic                        timer_event
);
	import bus_pkg::*;

	logic [DATA_W-1:0] period;
	logic [DATA_W-1:0] count;
	logic              wr_period;
	logic              running;

	// only the period is writable; bit 2 low selects it.
	assign wr_period = (reg_op == op_write) && timer_sel && !reg_addr[2];

	assign running = (period != '0);

	// the event marks the reload cycle.
	assign timer_event = running && (count == '0);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// period and counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			period <= '0;
			count  <= '0;
		end else if (wr_period) begin
			// a new period restarts the count at once.
			period <= reg_wdata;
			count  <= reg_wdata;
		end else if (running) begin
			if (count == '0) begin
				count <= period;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	// bit 2 high reads the live count, otherwise the period.
	assign timer_rdata = reg_addr[2] ? count : period;

endmodule

// ==== irq_controller.sv ====
// Interrupt controller with a mask and a sticky status register.
// Bit 0 of the mask is the global enable and is cleared whenever an
// interrupt is taken. Status bits are set by their sources and stay
// set until software writes them. A two-state FSM waits for the ack.

`timescale 1ns/100ps

module irq_controller (
	input  logic                         clk,
	input  logic                         rst,
	input  bus_pkg::bus_op_e             reg_op,
	input  logic [bus_pkg::ADDR_W-1:0]   reg_addr,
	input  logic [bus_pkg::DATA_W-1:0]   reg_wdata,
	input  logic                         ctrl_sel,
	input  logic                         timer_event,
	input  logic [irq_pkg::EXT_SRC-1:0]  ext_irq,
	input  logic                         irq_ack,
	output logic [bus_pkg::DATA_W-1:0]   ctrl_rdata,
	output logic [irq_pkg::NUM_SRC-1:0]  pending,
	output logic                         take
);
	import bus_pkg::*;
	import irq_pkg::*;

	// status bit 0 is not stored, it always reads as 1.
	logic [NUM_SRC-1:1] status;
	logic [NUM_SRC-1:0] mask;
	irq_state_e         state, state_next;

	logic [NUM_SRC-1:1] sources;
	logic [NUM_SRC-1:1] status_v;
	logic [NUM_SRC-1:0] mask_v;
	logic               wr_mask, wr_status;
	logic               take_now;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register writes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// bit 2 of the address separates mask from status.
	assign wr_mask   = (reg_op == op_write) && ctrl_sel && !reg_addr[2];
	assign wr_status = (reg_op == op_write) && ctrl_sel && reg_addr[2];

	// the timer sits at its own bit and the external lines above it.
	always_comb begin
		sources                         = '0;
		sources[SRC_TIMER]              = timer_event;
		sources[NUM_SRC-1:SRC_TIMER+1]  = ext_irq;
	end

	// a software write replaces the status, and any active source is
	// ORed on top so that no event is lost during the write.
	assign status_v = wr_status ? reg_wdata[NUM_SRC-1:1] : status;
	assign mask_v   = wr_mask ? reg_wdata[NUM_SRC-1:0] : mask;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// enabled and active sources; bit 0 is never a source.
	assign pending = {status & mask[NUM_SRC-1:1], 1'b0};

	// an interrupt is taken from idle with the global enable set.
	assign take_now = (state == st_idle) && mask[0] && (pending != '0);

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (take_now) begin
					state_next = st_wait_ack;
				end
			end
			st_wait_ack: begin
				// irq is not yet up while take is high, so an ack then
				// does not belong to this interrupt.
				if (irq_ack && !take) begin
					state_next = st_idle;
				end
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			status <= '0;
			mask   <= '0;
			state  <= st_idle;
			take   <= 1'b0;
		end else begin
			status <= status_v | sources;
			// the global enable clears even if software writes the mask
			// in the same cycle.
			mask   <= {mask_v[NUM_SRC-1:1], mask_v[0] && !take_now};
			state  <= state_next;
			take   <= take_now;
		end
	end

	// read data; unused upper bits are zero.
	assign ctrl_rdata = reg_addr[2]
		? {{(DATA_W-NUM_SRC){1'b0}}, status, 1'b1}
		: {{(DATA_W-NUM_SRC){1'b0}}, mask};

endmodule

// ==== irq_output_stage.sv ====
// Output side of the interrupt subsystem.
// Picks the lowest-numbered pending source, captures it as the cause
// when the controller takes an interrupt, and holds the processor's
// interrupt line until the ack.

`timescale 1ns/100ps

module irq_output_stage (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [irq_pkg::NUM_SRC-1:0]  pending,
	input  logic                         take,
	input  logic                         irq_ack,
	output logic                         irq,
	output logic [irq_pkg::CAUSE_W-1:0]  cause
);
	import irq_pkg::*;

	logic [CAUSE_W-1:0] lowest;

	// priority encoder; scanning downwards lets the lowest set bit win.
	always_comb begin
		lowest = '0;
		for (int i = NUM_SRC - 1; i >= 0; i--) begin
			if (pending[i]) begin
				lowest = CAUSE_W'(i);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// interrupt line and cause
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			irq   <= 1'b0;
			cause <= '0;
		end else if (take) begin
			// take has priority over a stray ack in the same cycle.
			irq   <= 1'b1;
			cause <= lowest;
		end else if (irq_ack) begin
			// the cause stays readable after the ack.
			irq <= 1'b0;
		end
	end

endmodule

// ==== intc_top.sv ====
// Top level of the APB interrupt subsystem.
// Connects the APB register port, the interval timer, the interrupt
// controller and the output stage that drives the processor's line.

`timescale 1ns/100ps

module intc_top (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [bus_pkg::ADDR_W-1:0]   paddr,
	input  logic [bus_pkg::DATA_W-1:0]   pwdata,
	output logic [bus_pkg::DATA_W-1:0]   prdata,
	output logic                         pready,
	output logic                         pslverr,
	input  logic [irq_pkg::EXT_SRC-1:0]  ext_irq,
	input  logic                         irq_ack,
	output logic                         irq,
	output logic [irq_pkg::CAUSE_W-1:0]  cause
);
	import bus_pkg::*;
	import irq_pkg::*;

	// register operation from the port to the blocks.
	bus_op_e           reg_op;
	logic [ADDR_W-1:0] reg_addr;
	logic [DATA_W-1:0] reg_wdata;
	logic              ctrl_sel, timer_sel;
	logic [DATA_W-1:0] ctrl_rdata, timer_rdata;

	// interrupt path between the blocks.
	logic               timer_event;
	logic [NUM_SRC-1:0] pending;
	logic               take;

	apb_reg_port i_apb_reg_port (
		.clk         (clk),
		.rst         (rst),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.reg_op      (reg_op),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.ctrl_sel    (ctrl_sel),
		.timer_sel   (timer_sel),
		.ctrl_rdata  (ctrl_rdata),
		.timer_rdata (timer_rdata),
		.cause       (cause)
	);

	irq_timer i_irq_timer (
		.clk         (clk),
		.rst         (rst),
		.reg_op      (reg_op),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.timer_sel   (timer_sel),
		.timer_rdata (timer_rdata),
		.timer_event (timer_event)
	);

	irq_controller i_irq_controller (
		.clk         (clk),
		.rst         (rst),
		.reg_op      (reg_op),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.ctrl_sel    (ctrl_sel),
		.timer_event (timer_event),
		.ext_irq     (ext_irq),
		.irq_ack     (irq_ack),
		.ctrl_rdata  (ctrl_rdata),
		.pending     (pending),
		.take        (take)
	);

	irq_output_stage i_irq_output_stage (
		.clk     (clk),
		.rst     (rst),
		.pending (pending),
		.take    (take),
		.irq_ack (irq_ack),
		.irq     (irq),
		.cause   (cause)
	);

endmodule

// ==== tb_clock_gen.sv ====
// Clock and reset generator for the interrupt subsystem testbench.
// Makes a 4 ns clock and holds the synchronous reset for 3 cycles.

`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	// free-running clock, half period of 2 ns.
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reset covers three rising edges and is released on a falling edge.
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== intc_properties.sv ====
// Concurrent assertions on the handshakes of the interrupt subsystem.
// Covers the interrupt line after reset and after an ack, the APB
// ready response and the length of the take pulse.

`timescale 1ns/100ps

module intc_properties (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic take,
	input logic irq,
	input logic irq_ack
);

	// number of assertion failures, read by the testbench at the end.
	int assert_fails = 0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// interrupt line
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// every reset cycle leaves the line low.
	irq_low_after_reset: assert property (@(posedge clk) rst |=> !irq)
		else begin
			$error("irq is high right after a reset cycle");
			assert_fails++;
		end

	// an ack while the line is up drops it at that very edge.
	irq_drops_on_ack: assert property (
		@(posedge clk) disable iff (rst) irq && irq_ack && !take |=> !irq)
		else begin
			$error("irq is still high one cycle after irq_ack");
			assert_fails++;
		end

	// take marks only the entry into st_wait_ack.
	take_one_cycle: assert property (@(posedge clk) disable iff (rst) take |=> !take)
		else begin
			$error("take stayed high for more than one cycle");
			assert_fails++;
		end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// zero wait states, so pready is up in every access phase.
	pready_in_access: assert property (
		@(posedge clk) disable iff (rst) psel && penable |-> pready)
		else begin
			$error("pready is low in an access phase");
			assert_fails++;
		end

endmodule

// ==== intc_tb.sv ====
// Testbench for the APB interrupt subsystem.
// Drives APB accesses, external sources and acks on the falling edge,
// keeps a reference model of mask, status, period and cause, and
// compares every register read in a separate process.

`timescale 1ns/100ps

module intc_tb;
	import bus_pkg::*;
	import irq_pkg::*;

	// cycle limits for each wait and for the whole run.
	localparam int TIMEOUT    = 200;
	localparam int MAX_CYCLES = 5000;

	logic               clk;
	logic               rst;
	logic               psel;
	logic               penable;
	logic               pwrite;
	logic [ADDR_W-1:0]  paddr;
	logic [DATA_W-1:0]  pwdata;
	logic [DATA_W-1:0]  prdata;
	logic               pready;
	logic               pslverr;
	logic [EXT_SRC-1:0] ext_irq;
	logic               irq_ack;
	logic               irq;
	logic [CAUSE_W-1:0] cause;

	int seed;
	int checks;
	int errors;
	int timeouts;

	// reference model state; bit 0 of m_status is not used.
	logic [NUM_SRC-1:0] m_mask;
	logic [NUM_SRC-1:0] m_status;
	logic [DATA_W-1:0]  m_period;
	logic [CAUSE_W-1:0] m_cause;

	// reads waiting for the compare process.
	logic [DATA_W-1:0] got_q[$];
	logic [DATA_W-1:0] exp_q[$];
	string             name_q[$];

	tb_clock_gen i_tb_clock_gen (
		.clk (clk),
		.rst (rst)
	);

	intc_top i_intc_top (
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.ext_irq (ext_irq),
		.irq_ack (irq_ack),
		.irq     (irq),
		.cause   (cause)
	);

	// the properties see the port, the controller and the output stage.
	bind intc_top intc_properties i_intc_properties (
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pready  (pready),
		.take    (take),
		.irq     (irq),
		.irq_ack (irq_ack)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_data(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_cause(input string name, input logic [CAUSE_W-1:0] got,
			input logic [CAUSE_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a write updates the model, a read returns what software should see.
	function automatic logic [DATA_W-1:0] model_regs(input bus_op_e op,
			input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
		logic [DATA_W-1:0] rd;
		rd = '0;
		if (op == op_write) begin
			case (addr)
				REG_MASK:   m_mask = wdata[NUM_SRC-1:0];
				REG_STATUS: m_status = wdata[NUM_SRC-1:0];
				REG_PERIOD: m_period = wdata;
				default: ;
			endcase
		end else if (op == op_read) begin
			case (addr)
				REG_MASK:   rd = DATA_W'(m_mask);
				REG_STATUS: rd = DATA_W'({m_status[NUM_SRC-1:1], 1'b1});
				REG_PERIOD: rd = m_period;
				REG_CAUSE:  rd = DATA_W'(m_cause);
				default:    rd = '0;
			endcase
		end
		return rd;
	endfunction

	// unmapped offsets and writes to the read-only registers are errors.
	function automatic logic bus_error(input logic wr, input logic [ADDR_W-1:0] addr);
		logic known;
		known = addr inside {REG_MASK, REG_STATUS, REG_PERIOD, REG_COUNT, REG_CAUSE};
		return !known || (wr && (addr == REG_COUNT || addr == REG_CAUSE));
	endfunction

	// taking an interrupt records the lowest enabled pending source
	// and clears the global enable.
	function automatic void model_take();
		logic found;
		found = 1'b0;
		for (int i = 1; i < NUM_SRC; i++) begin
			if (!found && m_status[i] && m_mask[i]) begin
				m_cause = CAUSE_W'(i);
				found   = 1'b1;
			end
		end
		m_mask[0] = 1'b0;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus and interrupt tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// one APB transfer; the response is sampled 1 ns into the access phase.
	task automatic apb_access(input logic wr, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] data, output logic [DATA_W-1:0] rdata,
			output logic err);
		int n;
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1;
		#1;
		// zero wait states, so the first access cycle already completes.
		check_bit("pready", pready, 1'b1);
		n = 0;
		while (!pready && n < TIMEOUT) begin
			@(negedge clk);
			#1;
			n++;
		end
		if (!pready) begin
			timeouts++;
			$display("timeout: pready never rose for address %h", addr);
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] rd;
		logic              err;
		apb_access(1'b1, addr, data, rd, err);
		check_bit("pslverr", err, bus_error(1'b1, addr));
		rd = model_regs(op_write, addr, data);
	endtask

	// the read result goes to the compare process with its expected value.
	task automatic apb_read(input logic [ADDR_W-1:0] addr, input string name);
		logic [DATA_W-1:0] rd;
		logic              err;
		apb_access(1'b0, addr, '0, rd, err);
		check_bit("pslverr", err, bus_error(1'b0, addr));
		got_q.push_back(rd);
		exp_q.push_back(model_regs(op_read, addr, '0));
		name_q.push_back(name);
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		while (irq !== level && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (irq !== level) begin
			timeouts++;
			$display("timeout: irq did not become %b within %0d cycles", level, TIMEOUT);
		end
	endtask

	// holds irq_ack for one edge, then the line must fall.
	task automatic ack_irq();
		@(negedge clk);
		irq_ack = 1'b1;
		@(negedge clk);
		irq_ack = 1'b0;
		wait_irq(1'b0);
	endtask

	task automatic expect_quiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			check_bit("irq", irq, 1'b0);
		end
	endtask

	// one edge of an external pattern; sticky status keeps it.
	task automatic pulse_ext(input logic [EXT_SRC-1:0] pat);
		@(negedge clk);
		ext_irq = pat;
		@(negedge clk);
		ext_irq = '0;
		m_status = m_status | {pat, 2'b00};
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare process and watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin : compare_reads
		logic [DATA_W-1:0] got;
		logic [DATA_W-1:0] exp;
		string             name;
		forever begin
			@(posedge clk);
			while (got_q.size() > 0) begin
				got  = got_q.pop_front();
				exp  = exp_q.pop_front();
				name = name_q.pop_front();
				check_data(name, got, exp);
			end
		end
	end

	initial begin : watchdog
		for (int i = 0; i < MAX_CYCLES; i++) begin
			@(posedge clk);
		end
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin : stimulus
		logic [DATA_W-1:0]  rd;
		logic               err;
		logic [EXT_SRC-1:0] pat;
		logic [NUM_SRC-1:0] en;
		int                 period;
		int                 n;
		seed     = 32'h6a38c14d;
		checks   = 0;
		errors   = 0;
		timeouts = 0;
		m_mask   = '0;
		m_status = '0;
		m_period = '0;
		m_cause  = '0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		ext_irq  = '0;
		irq_ack  = 1'b0;

		n = 0;
		while (rst !== 1'b0 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (rst !== 1'b0) begin
			timeouts++;
			$display("timeout: reset was never released");
		end

		// reset values.
		apb_read(REG_MASK, "prdata mask");
		apb_read(REG_STATUS, "prdata status");
		apb_read(REG_CAUSE, "prdata cause");
		check_bit("irq", irq, 1'b0);
		check_cause("cause", cause, '0);

		// read back, then the error responses.
		rd = $random(seed);
		apb_write(REG_MASK, {rd[DATA_W-1:1], 1'b0});
		apb_read(REG_MASK, "prdata mask");
		rd = $random(seed);
		apb_write(REG_PERIOD, rd | 32'h0040_0000);
		apb_read(REG_PERIOD, "prdata period");
		apb_write(REG_PERIOD, '0);
		apb_read(8'h14, "prdata unmapped");
		apb_write(8'h20, 32'hffff_ffff);
		apb_write(REG_CAUSE, 32'h0000_0005);
		apb_write(REG_COUNT, 32'h0000_0007);
		apb_read(REG_CAUSE, "prdata cause");

		// random sources with the global enable off never raise irq.
		for (int r = 0; r < 2; r++) begin
			rd  = $random(seed);
			pat = (rd[EXT_SRC-1:0] != '0) ? rd[EXT_SRC-1:0] : EXT_SRC'(1);
			pulse_ext(pat);
			expect_quiet(6);
			apb_read(REG_STATUS, "prdata status");
		end

		// enable some pending sources together with the global enable.
		rd = $random(seed);
		en = {rd[NUM_SRC-1:2], 2'b00};
		if ((en & m_status) == '0) begin
			en = m_status & 8'hfc;
		end
		apb_write(REG_MASK, DATA_W'({en[NUM_SRC-1:1], 1'b1}));
		wait_irq(1'b1);
		model_take();
		check_cause("cause", cause, m_cause);
		apb_read(REG_MASK, "prdata mask");
		apb_read(REG_CAUSE, "prdata cause");

		// after the ack the line stays low until the enable is rewritten.
		ack_irq();
		expect_quiet(8);
		apb_write(REG_MASK, DATA_W'({m_mask[NUM_SRC-1:1], 1'b1}));
		wait_irq(1'b1);
		model_take();
		check_cause("cause", cause, m_cause);
		ack_irq();

		// with status cleared, only a new enabled source raises it again.
		apb_write(REG_STATUS, '0);
		apb_write(REG_MASK, DATA_W'({m_mask[NUM_SRC-1:1], 1'b1}));
		expect_quiet(6);
		pat = en[NUM_SRC-1:2] & (~en[NUM_SRC-1:2] + 1'b1);
		pulse_ext(pat);
		wait_irq(1'b1);
		model_take();
		check_cause("cause", cause, m_cause);
		ack_irq();
		apb_read(REG_STATUS, "prdata status");
		apb_read(REG_CAUSE, "prdata cause");
		apb_write(REG_STATUS, '0);
		apb_write(REG_MASK, '0);

		// the timer event reaches status bit 1 within P+2 cycles.
		rd     = $random(seed);
		period = 4 + int'(rd[2:0]);
		apb_write(REG_PERIOD, period);
		for (int i = 0; i < period; i++) begin
			@(negedge clk);
		end
		m_status[SRC_TIMER] = 1'b1;
		apb_read(REG_STATUS, "prdata status");
		for (int i = 0; i < 6; i++) begin
			apb_access(1'b0, REG_COUNT, '0, rd, err);
			checks++;
			if (rd > DATA_W'(period)) begin
				errors++;
				$display("CHECK FAILED at %0t: prdata count got %0d expected at most %0d",
					$time, rd, period);
			end
		end
		apb_write(REG_PERIOD, '0);
		apb_write(REG_STATUS, '0);
		apb_read(REG_STATUS, "prdata status");
		check_bit("irq", irq, 1'b0);

		// let the compare process take the last reads.
		n = 0;
		while (got_q.size() > 0 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (got_q.size() > 0) begin
			timeouts++;
			$display("timeout: %0d reads were never compared", got_q.size());
		end

		$display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
			checks, errors, i_intc_top.i_intc_properties.assert_fails, timeouts);
		if (errors == 0 && timeouts == 0 && i_intc_top.i_intc_properties.assert_fails == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== intc_top.f ====
bus_pkg.sv
irq_pkg.sv
apb_reg_port.sv
irq_timer.sv
irq_controller.sv
irq_output_stage.sv
intc_top.sv
tb_clock_gen.sv
intc_properties.sv
intc_tb.sv

// ==== Bender.yml ====
package:
  name: intc

sources:
  - bus_pkg.sv
  - irq_pkg.sv
  - apb_reg_port.sv
  - irq_timer.sv
  - irq_controller.sv
  - irq_output_stage.sv
  - intc_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - intc_properties.sv
      - intc_tb.sv
